/* hdl/ex_pkg.sv */
package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and unit latencies
  ////////////////////////////////////////////////////////////

  localparam int xlen          = 32;
  localparam int reg_addr_bits = 5;

  // Start edge to done, counted in clock edges
  localparam int mul_cycles = 33;
  localparam int div_cycles = 34;

  ////////////////////////////////////////////////////////////
  // Operation and unit encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_LUI, OP_AUIPC, OP_LINK,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU
  } ex_op_t;

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_DIV
  } unit_t;

  // Which block produces the result of an op
  function automatic unit_t unit_of(input ex_op_t op);
    case (op)
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return UNIT_MUL;
      OP_DIV, OP_DIVU, OP_REM, OP_REMU:     return UNIT_DIV;
      default:                              return UNIT_ALU;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////

  // Decoded instruction from ID/EX
  typedef struct packed {
    logic                     valid;
    ex_op_t                   op;
    logic [reg_addr_bits-1:0] rs1;
    logic [reg_addr_bits-1:0] rs2;
    logic [reg_addr_bits-1:0] rd;
    logic [xlen-1:0]          rs1_val;
    logic [xlen-1:0]          rs2_val;
    logic [xlen-1:0]          imm;
    logic                     alusrc;
    logic                     regwrite;
    logic                     memread;
    logic                     memwrite;
    logic [xlen-1:0]          pc;
  } id_ex_t;

  // Registered EX/MEM contents
  typedef struct packed {
    logic                     valid;
    logic [reg_addr_bits-1:0] rd;
    logic                     regwrite;
    logic                     memread;
    logic                     memwrite;
    logic [xlen-1:0]          result;
    logic [xlen-1:0]          store_data;
    logic [xlen-1:0]          pc;
  } ex_mem_t;

  // Write-back view of a later stage
  typedef struct packed {
    logic                     regwrite;
    logic [reg_addr_bits-1:0] rd;
    logic [xlen-1:0]          value;
  } fwd_src_t;

endpackage

/* hdl/forwarding.sv */
module forwarding import ex_pkg::*; (
  input  id_ex_t          id_ex,
  input  fwd_src_t        ex_mem_fwd,
  input  fwd_src_t        mem_wb,
  output logic [xlen-1:0] op_a,
  output logic [xlen-1:0] op_b,
  output logic [xlen-1:0] store_data
);

  logic [xlen-1:0] rs1_fwd;
  logic [xlen-1:0] rs2_fwd;

  // Source writes a non-zero register equal to the one read
  function automatic logic hits(
    input fwd_src_t                 src,
    input logic [reg_addr_bits-1:0] rs
  );
    return src.regwrite && (src.rd != '0) && (src.rd == rs);
  endfunction

  // Priority pick for one operand
  // Younger EX/MEM value beats MEM/WB
  function automatic logic [xlen-1:0] pick(
    input logic [reg_addr_bits-1:0] rs,
    input logic [xlen-1:0]          rf_val,
    input fwd_src_t                 ex_src,
    input fwd_src_t                 wb_src
  );
    if (hits(ex_src, rs)) begin
      return ex_src.value;
    end
    if (hits(wb_src, rs)) begin
      return wb_src.value;
    end
    // Register file value is current
    return rf_val;
  endfunction

  // rs1 comparators
  assign rs1_fwd = pick(id_ex.rs1, id_ex.rs1_val, ex_mem_fwd, mem_wb);

  // rs2 comparators
  assign rs2_fwd = pick(id_ex.rs2, id_ex.rs2_val, ex_mem_fwd, mem_wb);

  assign op_a = rs1_fwd;

  // Immediate replaces rs2 for I-type and upper-immediate ops
  assign op_b = id_ex.alusrc ? id_ex.imm : rs2_fwd;

  // Stores always need the real rs2 value
  assign store_data = rs2_fwd;

endmodule

/* hdl/alu.sv */
module alu import ex_pkg::*; (
  input  ex_op_t          op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  logic [xlen-1:0] pc,
  output logic [xlen-1:0] result
);

  // Shift amount from low five bits only
  logic [4:0] shamt;

  // Shared adder outputs
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;

  // Compare results
  logic lt_signed;
  logic lt_unsigned;

  // Return address for JAL and JALR
  logic [xlen-1:0] link_addr;

  assign shamt = b[4:0];

  assign sum  = a + b;
  assign diff = a - b;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  assign link_addr = pc + xlen'(4);

  always_comb begin
    case (op)
      // Arithmetic
      OP_ADD: result = sum;
      OP_SUB: result = diff;

      // Bitwise logic
      OP_AND: result = a & b;
      OP_OR:  result = a | b;
      OP_XOR: result = a ^ b;

      // Shifts
      OP_SLL: result = a << shamt;
      OP_SRL: result = a >> shamt;
      OP_SRA: result = $signed(a) >>> shamt;

      // Set less than, zero extended flag
      OP_SLT:  result = {{(xlen-1){1'b0}}, lt_signed};
      OP_SLTU: result = {{(xlen-1){1'b0}}, lt_unsigned};

      // Upper immediate already shifted by decode
      OP_LUI:   result = b;
      OP_AUIPC: result = pc + b;

      // Link value for jumps
      OP_LINK: result = link_addr;

      // M ops come from the multi-cycle units
      default: result = sum;
    endcase
  end

endmodule

/* hdl/multiplier.sv */
module multiplier import ex_pkg::*; (
  input  logic            bus,
  input  logic            reset,
  input  logic            start,
  input  ex_op_t          op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic            busy,
  output logic            done,
  output logic [xlen-1:0] result
);

  typedef logic [$clog2(mul_cycles)-1:0] count_t;

  // Operand signedness for the requested op
  logic            a_signed;
  logic            b_signed;
  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;

  // Iteration state
  count_t            count;
  logic              last;
  logic [2*xlen-1:0] acc;
  logic [2*xlen-1:0] mcand;
  logic [xlen-1:0]   mplier;
  logic              neg_prod;
  logic              high_word;
  logic [2*xlen-1:0] prod_fixed;

  // MUL low word is the same either way
  assign a_signed = (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU);
  assign b_signed = (op == OP_MUL) || (op == OP_MULH);

  assign a_neg = a_signed & a[xlen-1];
  assign b_neg = b_signed & b[xlen-1];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  // 32 shift-add steps then one sign fix edge
  assign last       = (count == count_t'(mul_cycles - 1));
  assign prod_fixed = neg_prod ? -acc : acc;

  // Control
  always_ff @(posedge bus) begin
    if (reset) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge bus) begin
    if (start) begin
      acc       <= '0;
      mcand     <= {{xlen{1'b0}}, a_mag};
      mplier    <= b_mag;
      neg_prod  <= a_neg ^ b_neg;
      high_word <= (op != OP_MUL);
    end else if (busy) begin
      if (last) begin
        result <= high_word ? prod_fixed[2*xlen-1:xlen] : prod_fixed[xlen-1:0];
      end else begin
        // Add partial product for current multiplier bit
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
    end
  end

endmodule

/* hdl/divider.sv */
module divider import ex_pkg::*; (
  input  logic            bus,
  input  logic            reset,
  input  logic            start,
  input  ex_op_t          op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic            busy,
  output logic            done,
  output logic [xlen-1:0] result
);

  typedef logic [$clog2(div_cycles)-1:0] count_t;

  // Operand signs and magnitudes
  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;

  // Iteration state
  count_t          count;
  logic            stepping;
  logic            fix_stage;
  logic            last;
  logic [xlen-1:0] rem;
  logic [xlen-1:0] quo;
  logic [xlen-1:0] dvsr;
  logic            q_neg;
  logic            r_neg;
  logic            want_rem;
  logic            div_zero;

  // Trial subtract
  logic [xlen:0]   shifted;
  logic [xlen:0]   diff;
  logic            fits;

  // Signed results
  logic [xlen-1:0] q_fix;
  logic [xlen-1:0] r_fix;

  assign is_signed = (op == OP_DIV) || (op == OP_REM);
  assign a_neg     = is_signed & a[xlen-1];
  assign b_neg     = is_signed & b[xlen-1];
  assign a_mag     = a_neg ? -a : a;
  assign b_mag     = b_neg ? -b : b;

  ////////////////////////////////////////////////////////////
  // Schedule
  ////////////////////////////////////////////////////////////

  // Count 0..31 one quotient bit each
  assign stepping  = (count < count_t'(xlen));
  // Count 32 applies signs
  assign fix_stage = (count == count_t'(xlen));
  // Final count raises done
  assign last      = (count == count_t'(div_cycles - 1));

  // Bring down next dividend bit
  assign shifted = {rem, quo[xlen-1]};
  assign diff    = shifted - {1'b0, dvsr};
  assign fits    = (shifted >= {1'b0, dvsr});

  // Quotient sign from both operands
  // Zero divisor forces all ones
  assign q_fix = div_zero ? '1 : (q_neg ? -quo : quo);

  // Remainder sign follows dividend
  // Zero divisor leaves the dividend here by itself
  // Most negative over minus one also falls out of the magnitudes
  assign r_fix = r_neg ? -rem : rem;

  // Control
  always_ff @(posedge bus) begin
    if (reset) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Restoring datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (start) begin
      rem      <= '0;
      quo      <= a_mag;
      dvsr     <= b_mag;
      q_neg    <= a_neg ^ b_neg;
      r_neg    <= a_neg;
      want_rem <= (op == OP_REM) || (op == OP_REMU);
      div_zero <= (b == '0);
    end else if (busy) begin
      if (stepping) begin
        if (fits) begin
          rem <= diff[xlen-1:0];
          quo <= {quo[xlen-2:0], 1'b1};
        end else begin
          rem <= shifted[xlen-1:0];
          quo <= {quo[xlen-2:0], 1'b0};
        end
      end else if (fix_stage) begin
        result <= want_rem ? r_fix : q_fix;
      end
    end
  end

endmodule

/* hdl/execute.sv */
module execute import ex_pkg::*; (
  input  logic     bus,
  input  logic     reset,
  input  id_ex_t   id_ex,
  input  fwd_src_t mem_wb,
  input  logic     mem_hold,
  output ex_mem_t  ex_mem,
  output logic     stall
);

  unit_t           unit;
  fwd_src_t        ex_mem_fwd;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] store_data;

  // Unit results
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] mul_result;
  logic [xlen-1:0] div_result;
  logic [xlen-1:0] ex_result;

  // Multi-cycle handshake levels
  logic mul_start;
  logic mul_busy;
  logic mul_done;
  logic div_start;
  logic div_busy;
  logic div_done;
  logic done_hold;
  logic unit_stall;

  ex_mem_t ex_mem_next;

  ////////////////////////////////////////////////////////////
  // Operand path
  ////////////////////////////////////////////////////////////

  // Loads in EX/MEM have no data yet
  assign ex_mem_fwd.regwrite = ex_mem.valid & ex_mem.regwrite & ~ex_mem.memread;
  assign ex_mem_fwd.rd       = ex_mem.rd;
  assign ex_mem_fwd.value    = ex_mem.result;

  forwarding u_fwd (
    .id_ex      (id_ex),
    .ex_mem_fwd (ex_mem_fwd),
    .mem_wb     (mem_wb),
    .op_a       (op_a),
    .op_b       (op_b),
    .store_data (store_data)
  );

  alu u_alu (
    .op     (id_ex.op),
    .a      (op_a),
    .b      (op_b),
    .pc     (id_ex.pc),
    .result (alu_result)
  );

  multiplier u_mul (
    .bus    (bus),
    .reset  (reset),
    .start  (mul_start),
    .op     (id_ex.op),
    .a      (op_a),
    .b      (op_b),
    .busy   (mul_busy),
    .done   (mul_done),
    .result (mul_result)
  );

  divider u_div (
    .bus    (bus),
    .reset  (reset),
    .start  (div_start),
    .op     (id_ex.op),
    .a      (op_a),
    .b      (op_b),
    .busy   (div_busy),
    .done   (div_done),
    .result (div_result)
  );

  ////////////////////////////////////////////////////////////
  // Start and stall
  ////////////////////////////////////////////////////////////

  assign unit = unit_of(id_ex.op);

  // Done seen under memory hold stays pending until hold drops
  // Unit result register keeps its value meanwhile
  always_ff @(posedge bus) begin
    if (reset) begin
      done_hold <= 1'b0;
    end else if (!mem_hold) begin
      done_hold <= 1'b0;
    end else if (mul_done || div_done) begin
      done_hold <= 1'b1;
    end
  end

  // One start per held instruction
  assign mul_start = id_ex.valid && (unit == UNIT_MUL) && !mul_busy && !mul_done && !done_hold;
  assign div_start = id_ex.valid && (unit == UNIT_DIV) && !div_busy && !div_done && !done_hold;

  // Start cycle through last busy cycle
  assign unit_stall = mul_start | mul_busy | div_start | div_busy;
  assign stall      = unit_stall | mem_hold;

  // Result source
  always_comb begin
    case (unit)
      UNIT_MUL: ex_result = mul_result;
      UNIT_DIV: ex_result = div_result;
      default:  ex_result = alu_result;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////

  // Bubble while a unit is still working
  always_comb begin
    ex_mem_next.valid      = id_ex.valid & ~unit_stall;
    ex_mem_next.rd         = id_ex.rd;
    ex_mem_next.regwrite   = id_ex.valid & ~unit_stall & id_ex.regwrite;
    ex_mem_next.memread    = id_ex.valid & ~unit_stall & id_ex.memread;
    ex_mem_next.memwrite   = id_ex.valid & ~unit_stall & id_ex.memwrite;
    ex_mem_next.result     = ex_result;
    ex_mem_next.store_data = store_data;
    ex_mem_next.pc         = id_ex.pc;
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      ex_mem.valid    <= 1'b0;
      ex_mem.regwrite <= 1'b0;
      ex_mem.memread  <= 1'b0;
      ex_mem.memwrite <= 1'b0;
    end else if (!mem_hold) begin
      ex_mem <= ex_mem_next;
    end
  end

endmodule

/* tests/execute_assert.sv */
module execute_assert import ex_pkg::*; (
  input logic    bus,
  input logic    reset,
  input logic    stall,
  input logic    mem_hold,
  input ex_mem_t ex_mem
);

  // Quiet pipeline right out of reset
  assert property (@(posedge bus) reset |=> (!stall && !ex_mem.valid))
    else $error("stall or EX/MEM valid high after reset");

  // Unit stall pushes bubbles into EX/MEM
  assert property (@(posedge bus) disable iff (reset)
    (stall && !mem_hold) |=> !ex_mem.valid)
    else $error("EX/MEM valid after a unit stall cycle");

  // Memory hold freezes the register
  assert property (@(posedge bus) disable iff (reset)
    mem_hold |=> $stable(ex_mem))
    else $error("EX/MEM changed under memory hold");

endmodule

bind execute execute_assert asrt0 (
  .bus      (bus),
  .reset    (reset),
  .stall    (stall),
  .mem_hold (mem_hold),
  .ex_mem   (ex_mem)
);

/* tests/execute_checker.sv */
module execute_checker import ex_pkg::*; (
  input logic     bus,
  input logic     reset,
  input id_ex_t   id_ex,
  input fwd_src_t mem_wb,
  input logic     mem_hold,
  input logic     stall,
  input ex_mem_t  ex_mem
);

  int pass_count = 0;
  int fail_count = 0;
  int stall_fail = 0;
  int seq = 0;

  // Expected EX/MEM loads in issue order
  ex_mem_t exp_q[$];
  string   name_q[$];

  // Expected current EX/MEM contents
  ex_mem_t shadow;
  logic    loaded;
  logic    expect_valid;
  // Next valid id_ex is a new instruction
  logic    fresh;
  logic [xlen-1:0] cap_a;
  logic [xlen-1:0] cap_b;
  ex_mem_t exp_e;
  string   nm;

  // Cycles the current instruction has sat in ID/EX
  int   age;
  // Stall cycles its unit needs before EX/MEM takes it
  int   wait_len;
  logic exp_stall;

  // Priority forwarding, EX/MEM before MEM/WB, loads excluded
  function automatic logic [xlen-1:0] fwd_val(
    input logic [reg_addr_bits-1:0] rs,
    input logic [xlen-1:0]          rf_val,
    input ex_mem_t                  em,
    input fwd_src_t                 wb
  );
    if (em.valid && em.regwrite && !em.memread && em.rd != 0 && em.rd == rs) begin
      return em.result;
    end
    if (wb.regwrite && wb.rd != 0 && wb.rd == rs) begin
      return wb.value;
    end
    return rf_val;
  endfunction

  // Expected result from the RV32IM rules
  function automatic logic [xlen-1:0] ex_ref(
    input ex_op_t          op,
    input logic [xlen-1:0] a,
    input logic [xlen-1:0] b,
    input logic [xlen-1:0] pc
  );
    logic [63:0] p;
    logic        ovf;
    p   = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      OP_ADD:    return a + b;
      OP_SUB:    return a - b;
      OP_AND:    return a & b;
      OP_OR:     return a | b;
      OP_XOR:    return a ^ b;
      OP_SLL:    return a << b[4:0];
      OP_SRL:    return a >> b[4:0];
      OP_SRA:    return 32'($signed(a) >>> b[4:0]);
      OP_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU:   return (a < b) ? 32'd1 : 32'd0;
      OP_LUI:    return b;
      OP_AUIPC:  return pc + b;
      OP_LINK:   return pc + 32'd4;
      OP_MUL:    return p[31:0];
      OP_MULH:   return p[63:32];
      OP_MULHSU: return 32'(({{32{a[31]}}, a} * {32'd0, b}) >> 32);
      OP_MULHU:  return 32'(({32'd0, a} * {32'd0, b}) >> 32);
      // Zero divisor and overflow first
      OP_DIV:    return (b == 0) ? '1 : (ovf ? a : 32'($signed(a) / $signed(b)));
      OP_DIVU:   return (b == 0) ? '1 : a / b;
      OP_REM:    return (b == 0) ? a : (ovf ? 32'd0 : 32'($signed(a) % $signed(b)));
      OP_REMU:   return (b == 0) ? a : a % b;
      default:   return 32'd0;
    endcase
  endfunction

  // Sampled mid-cycle where every input is settled
  always @(negedge bus) begin
    if (reset) begin
      exp_q.delete();
      name_q.delete();
      shadow       = '0;
      loaded       = 1'b0;
      expect_valid = 1'b0;
      fresh        = 1'b1;
      age          = 0;
      wait_len     = 0;
    end else begin
      ////////////////////////////////////////////////////////////
      // Outcome of the previous edge
      ////////////////////////////////////////////////////////////
      if (loaded && expect_valid) begin
        exp_e = exp_q.pop_front();
        nm    = name_q.pop_front();
        if (!ex_mem.valid) begin
          $display("[ERROR] %s valid: expected %h, actual %h", nm, 1'b1, ex_mem.valid);
          fail_count++;
        end else if (ex_mem.result != exp_e.result) begin
          $display("[ERROR] %s result: expected %h, actual %h", nm, exp_e.result,
                   ex_mem.result);
          fail_count++;
        end else if ({ex_mem.rd, ex_mem.regwrite, ex_mem.memread, ex_mem.memwrite} !=
                     {exp_e.rd, exp_e.regwrite, exp_e.memread, exp_e.memwrite}) begin
          $display("[ERROR] %s rd/ctl: expected %h, actual %h", nm,
                   {exp_e.rd, exp_e.regwrite, exp_e.memread, exp_e.memwrite},
                   {ex_mem.rd, ex_mem.regwrite, ex_mem.memread, ex_mem.memwrite});
          fail_count++;
        end else if (ex_mem.store_data != exp_e.store_data) begin
          $display("[ERROR] %s store_data: expected %h, actual %h", nm,
                   exp_e.store_data, ex_mem.store_data);
          fail_count++;
        end else if (ex_mem.pc != exp_e.pc) begin
          $display("[ERROR] %s pc: expected %h, actual %h", nm, exp_e.pc, ex_mem.pc);
          fail_count++;
        end else begin
          $display("[PASS] %s result %h", nm, ex_mem.result);
          pass_count++;
        end
      end else if (loaded && ex_mem.valid) begin
        $display("EX/MEM holds a valid entry where a stall bubble was due");
        fail_count++;
      end

      ////////////////////////////////////////////////////////////
      // Prediction for the coming edge
      ////////////////////////////////////////////////////////////
      // Units latch operands on the first cycle
      if (id_ex.valid && fresh) begin
        cap_a = fwd_val(id_ex.rs1, id_ex.rs1_val, shadow, mem_wb);
        cap_b = id_ex.alusrc ? id_ex.imm : fwd_val(id_ex.rs2, id_ex.rs2_val, shadow, mem_wb);
        age   = 0;
        // Start cycle plus the unit's own latency
        case (id_ex.op)
          OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: wait_len = mul_cycles + 1;
          OP_DIV, OP_DIVU, OP_REM, OP_REMU:     wait_len = div_cycles + 1;
          default:                              wait_len = 0;
        endcase
        fresh = 1'b0;
      end

      // Stall from unit latency, or memory hold
      exp_stall = mem_hold || (id_ex.valid && (age < wait_len));
      if (stall !== exp_stall) begin
        if (id_ex.valid) begin
          nm = $sformatf("%s #%0d", id_ex.op.name(), seq);
        end else begin
          nm = "idle";
        end
        $display("[ERROR] %s stall: expected %b, actual %b", nm, exp_stall, stall);
        stall_fail++;
      end
      age++;

      loaded       = !mem_hold;
      expect_valid = 1'b0;
      if (!mem_hold) begin
        if (id_ex.valid && !exp_stall) begin
          exp_e.valid      = 1'b1;
          exp_e.rd         = id_ex.rd;
          exp_e.regwrite   = id_ex.regwrite;
          exp_e.memread    = id_ex.memread;
          exp_e.memwrite   = id_ex.memwrite;
          exp_e.result     = ex_ref(id_ex.op, cap_a, cap_b, id_ex.pc);
          // Store data forwarded at load time
          exp_e.store_data = fwd_val(id_ex.rs2, id_ex.rs2_val, shadow, mem_wb);
          exp_e.pc         = id_ex.pc;
          exp_q.push_back(exp_e);
          name_q.push_back($sformatf("%s #%0d", id_ex.op.name(), seq));
          seq++;
          shadow       = exp_e;
          expect_valid = 1'b1;
          fresh        = 1'b1;
        end else begin
          shadow.valid    = 1'b0;
          shadow.regwrite = 1'b0;
          shadow.memread  = 1'b0;
          shadow.memwrite = 1'b0;
        end
      end
    end
  end

endmodule

/* tests/execute_tb.sv */
module execute_tb import ex_pkg::*; ();

  logic     bus;
  logic     reset;
  id_ex_t   id_ex;
  fwd_src_t mem_wb;
  logic     mem_hold;
  ex_mem_t  ex_mem;
  logic     stall;

  int seed = 32'h1eaa_a9c9;
  int issued = 0;
  // ALU, forwarding, MUL, DIV, hold phase
  int planned = 40 + 14 + 96 + 96 + 30;
  logic hold_on = 1'b0;
  logic hold_pick;
  logic [xlen-1:0] pc_ctr = 32'h0000_1000;

  // Decode-side register file
  logic [xlen-1:0] rf [32];

  // EX/MEM view taken mid-cycle for MEM/WB
  ex_mem_t em_s;
  logic    hold_s;

  execute dut0 (
    .bus      (bus),
    .reset    (reset),
    .id_ex    (id_ex),
    .mem_wb   (mem_wb),
    .mem_hold (mem_hold),
    .ex_mem   (ex_mem),
    .stall    (stall)
  );

  execute_checker chk0 (
    .bus      (bus),
    .reset    (reset),
    .id_ex    (id_ex),
    .mem_wb   (mem_wb),
    .mem_hold (mem_hold),
    .stall    (stall),
    .ex_mem   (ex_mem)
  );

  initial bus = 1'b0;
  always #20 bus = ~bus;

  ////////////////////////////////////////////////////////////
  // Writeback and memory model
  ////////////////////////////////////////////////////////////

  always @(negedge bus) begin
    em_s   = ex_mem;
    hold_s = mem_hold;
  end

  always @(posedge bus) begin
    if (!reset && mem_wb.regwrite && mem_wb.rd != 0) begin
      rf[mem_wb.rd] <= mem_wb.value;
    end
  end

  always @(posedge bus) begin
    // Hold drawn one unit before the stimulus draws
    #1;
    hold_pick = hold_on && (($random(seed) & 3) == 0);
    #1;
    if (reset) begin
      mem_wb <= '0;
    end else if (!hold_s) begin
      mem_wb.regwrite <= em_s.valid & em_s.regwrite;
      mem_wb.rd       <= em_s.rd;
      // Load data differs from the address
      mem_wb.value    <= em_s.memread ? (em_s.result ^ 32'h5a5a_0f0f) : em_s.result;
    end
    mem_hold <= hold_pick;
  end

  // Random register in base..base+span-1
  function automatic logic [4:0] rand_reg(input int base, input int span);
    int r;
    r = $random(seed);
    return 5'(base + ((r & 32'h7fff_ffff) % span));
  endfunction

  // Drive one instruction, hold it until EX takes it
  task automatic issue(
    input ex_op_t op, input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
    input logic [xlen-1:0] imm, input logic alusrc, input logic mr, input logic mw
  );
    id_ex_t d;
    d.valid    = 1'b1;
    d.op       = op;
    d.rs1      = rs1;
    d.rs2      = rs2;
    d.rd       = rd;
    d.rs1_val  = rf[rs1];
    d.rs2_val  = rf[rs2];
    d.imm      = imm;
    d.alusrc   = alusrc;
    d.regwrite = !mw;
    d.memread  = mr;
    d.memwrite = mw;
    d.pc       = pc_ctr;
    pc_ctr     = pc_ctr + 4;
    id_ex      = d;
    issued++;
    @(negedge bus);
    while (stall) begin
      @(negedge bus);
    end
    @(posedge bus);
    #2;
  endtask

  task automatic idle(input int n);
    id_ex.valid = 1'b0;
    repeat (n) begin
      @(posedge bus);
      #2;
    end
  endtask

  // Watchdog sized for the slowest op per test
  initial begin
    #(planned * (div_cycles + 4) * 40 + 8000);
    $display("Run timed out before all tests finished");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int r;
    ex_op_t op_sel;
    logic [xlen-1:0] imm;
    logic src;
    logic [xlen-1:0] ev [4];
    ev[0] = 32'h0000_0000;
    ev[1] = 32'h0000_0001;
    ev[2] = 32'hffff_ffff;
    ev[3] = 32'h8000_0000;
    id_ex    = '0;
    mem_wb   = '0;
    mem_hold = 1'b0;
    reset    = 1'b1;
    for (int i = 0; i < 32; i++) begin
      rf[i] = $random(seed);
    end
    rf[0] = '0;
    // Edge operands live in x24..x27, never written
    for (int i = 0; i < 4; i++) begin
      rf[24 + i] = ev[i];
    end
    repeat (3) @(posedge bus);
    #2;
    reset = 1'b0;
    idle(2);

    ////////////////////////////////////////////////////////////
    // ALU ops, sources x16..x31, targets x1..x15
    ////////////////////////////////////////////////////////////
    for (int k = 0; k < 40; k++) begin
      r      = $random(seed);
      op_sel = ex_op_t'(5'((r & 32'h7fff_ffff) % 13));
      imm    = $random(seed);
      src    = 1'($random(seed));
      if (op_sel == OP_LUI || op_sel == OP_AUIPC) begin
        src       = 1'b1;
        imm[11:0] = '0;
      end
      issue(op_sel, rand_reg(16, 16), rand_reg(16, 16), 5'(1 + k % 15), imm, src, 0, 0);
    end

    // Forwarding cases
    issue(OP_ADD, 16, 17, 5, 0, 0, 0, 0);
    issue(OP_ADD, 5, 18, 6, 0, 0, 0, 0);
    issue(OP_ADD, 19, 20, 7, 0, 0, 0, 0);
    issue(OP_XOR, 21, 22, 8, 0, 0, 0, 0);
    issue(OP_SUB, 7, 23, 9, 0, 0, 0, 0);
    issue(OP_ADD, 16, 17, 10, 0, 0, 0, 0);
    issue(OP_OR, 18, 19, 10, 0, 0, 0, 0);
    issue(OP_ADD, 10, 10, 11, 0, 0, 0, 0);
    issue(OP_ADD, 16, 17, 0, 0, 0, 0, 0);
    issue(OP_ADD, 0, 18, 12, 0, 0, 0, 0);
    // Load straight into a dependent op, then one a bubble later
    issue(OP_ADD, 16, 0, 13, 32'h40, 1, 1, 0);
    issue(OP_ADD, 13, 17, 14, 0, 0, 0, 0);
    issue(OP_ADD, 18, 0, 13, 32'h80, 1, 1, 0);
    idle(1);
    issue(OP_SUB, 13, 19, 14, 0, 0, 0, 1);

    ////////////////////////////////////////////////////////////
    // Multiply then divide, edge pairs and random pairs
    ////////////////////////////////////////////////////////////
    for (int u = 0; u < 2; u++) begin
      for (int o = 0; o < 4; o++) begin
        op_sel = ex_op_t'(int'(u == 0 ? OP_MUL : OP_DIV) + o);
        for (int i = 0; i < 4; i++) begin
          for (int j = 0; j < 4; j++) begin
            issue(op_sel, 5'(24 + i), 5'(24 + j), 5'(1 + (i * 4 + j) % 15), 0, 0, 0, 0);
          end
        end
        for (int k = 0; k < 8; k++) begin
          issue(op_sel, rand_reg(16, 8), rand_reg(16, 8), rand_reg(1, 15), 0, 0, 0, 0);
        end
      end
    end

    // Mixed ops under random memory hold
    hold_on = 1'b1;
    for (int k = 0; k < 30; k++) begin
      r      = $random(seed);
      op_sel = ex_op_t'(5'((r & 32'h7fff_ffff) % 21));
      src    = (unit_of(op_sel) == UNIT_ALU) ? 1'($random(seed)) : 1'b0;
      imm    = $random(seed);
      issue(op_sel, rand_reg(1, 31), rand_reg(1, 31), rand_reg(1, 15), imm, src, 0, 0);
    end
    hold_on = 1'b0;
    idle(6);

    $display("Tests: %0d passed, %0d failed, %0d issued, %0d stall errors",
             chk0.pass_count, chk0.fail_count, issued, chk0.stall_fail);
    if (chk0.pass_count + chk0.fail_count != issued) begin
      $display("Number of checked results does not match issued instructions");
    end
    if (chk0.fail_count == 0 && chk0.stall_fail == 0 && chk0.pass_count == issued &&
        issued == planned) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
hdl/ex_pkg.sv
hdl/forwarding.sv
hdl/alu.sv
hdl/multiplier.sv
hdl/divider.sv
hdl/execute.sv
tests/execute_assert.sv
tests/execute_checker.sv
tests/execute_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = execute_tb
FILELIST = all.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
